/* common/mvu_defines.svh */
// Lane count, field widths, RAM depth and register offsets for the MVU
`ifndef MVU_DEFINES_SVH
`define MVU_DEFINES_SVH

`define MVU_N        4      // Lanes and output rows
`define MVU_BPREC    3      // Precision fields hold precision minus 1
`define MVU_BADDR    6      // RAM address width
`define MVU_DEPTH    64     // Words per RAM
`define MVU_BLEN     4      // Block count minus 1
`define MVU_BACC     16     // Lane accumulator
`define MVU_BSCALER  16
`define MVU_BQMSB    5      // Quantizer MSB index into the scaled product
`define MVU_OUTW     8      // Result field per lane
`define MVU_WB_AW    10     // Word address, top two bits select the region
`define MVU_WB_DW    32

`define MVU_REG_CTRL   0
`define MVU_REG_PREC   1
`define MVU_REG_LEN    2
`define MVU_REG_BASE   3
`define MVU_REG_SCALE  4

`endif

/* common/mvu_cfg_pkg.sv */
// Job configuration struct, bus region enum and control/status bit positions
`default_nettype none

`include "mvu_defines.svh"

package mvu_cfg_pkg;

    typedef struct packed {
        logic [`MVU_BPREC-1:0]   wprec;          // Weight bits minus 1
        logic [`MVU_BPREC-1:0]   iprec;          // Input bits minus 1
        logic [`MVU_BPREC-1:0]   oprec;          // Result field bits minus 1
        logic                    w_signed;
        logic                    i_signed;
        logic [`MVU_BLEN-1:0]    len;            // Blocks minus 1
        logic [`MVU_BADDR-1:0]   wbase;
        logic [`MVU_BADDR-1:0]   ibase;
        logic [`MVU_BADDR-1:0]   obase;
        logic [`MVU_BSCALER-1:0] scaler_b;       // Unsigned multiplier
        logic [`MVU_BQMSB-1:0]   quant_msbidx;
    } job_cfg_t;

    typedef enum logic [1:0] {
        region_regs    = 2'd0,
        region_weights = 2'd1,
        region_inputs  = 2'd2,
        region_results = 2'd3
    } wb_region_e;

    localparam int ctrl_start_bit = 0;           // CTRL write
    localparam int ctrl_clear_bit = 1;
    localparam int stat_busy_bit  = 0;           // CTRL read
    localparam int stat_done_bit  = 1;

endpackage

`default_nettype wire

/* common/mvu_pipe_pkg.sv */
// Memory word types and the payload structs passed between pipeline stages
`default_nettype none

`include "mvu_defines.svh"

package mvu_pipe_pkg;

    // Bit r*N+k is row r, lane k
    typedef logic [`MVU_N*`MVU_N-1:0] wword_t;

    typedef logic [`MVU_N-1:0] dword_t;          // One input bit plane

    typedef logic [`MVU_N*`MVU_OUTW-1:0] rword_t; // Lane r at bits r*OUTW upward

    typedef struct packed {
        logic                  valid;
        logic                  first;            // Restart the accumulators
        logic                  last;             // Hand the sums off
        logic [`MVU_BPREC:0]   shift;            // Weight bit plus input bit
        logic                  neg;              // Plane carries a signed MSB
    } plane_t;

    typedef struct packed {
        logic                              valid;
        logic [`MVU_N-1:0][`MVU_BACC-1:0]  sum;  // Two's complement lane sums
    } acc_t;

endpackage

`default_nettype wire

/* verilog/mvu_ram.sv */
// Simple dual-port RAM with registered read, typed on its word
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_ram #(
    parameter type word_t = logic [7:0]
) (
    input  logic                  intf,
    input  logic                  we,
    input  logic [`MVU_BADDR-1:0] waddr,
    input  word_t                 wdata,
    input  logic [`MVU_BADDR-1:0] raddr,
    output word_t                 rdata
);

    word_t mem [`MVU_DEPTH];

    always_ff @(posedge intf) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];                     // One cycle read latency
    end

endmodule

`default_nettype wire

/* verilog/mvu_wb_regs.sv */
// Wishbone classic slave with job configuration, control/status, irq and RAM access
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

// Register layout
//   PREC  wprec [2:0], iprec [6:4], oprec [10:8], w_signed [12], i_signed [13]
//   LEN   len [3:0]
//   BASE  wbase [5:0], ibase [13:8], obase [21:16]
//   SCALE scaler_b [15:0], quant_msbidx [20:16]
module mvu_wb_regs (
    input  logic                   intf,
    input  logic                   rst_n,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`MVU_WB_AW-1:0]  adr,
    input  logic [`MVU_WB_DW-1:0]  dat_w,
    output logic [`MVU_WB_DW-1:0]  dat_r,
    output logic                   ack,
    output logic                   irq,
    output mvu_cfg_pkg::job_cfg_t  cfg,
    output logic                   start,
    input  logic                   busy_done,
    output logic                   w_we,
    output logic                   d_we,
    output logic [`MVU_BADDR-1:0]  bus_waddr,
    output mvu_pipe_pkg::wword_t   bus_wword,
    output mvu_pipe_pkg::dword_t   bus_dword,
    output logic [`MVU_BADDR-1:0]  r_raddr,
    input  mvu_pipe_pkg::rword_t   r_rdata
);

    mvu_cfg_pkg::wb_region_e region;
    mvu_cfg_pkg::wb_region_e region_q;           // Steers dat_r in the ack cycle
    logic                    req;                // First cycle of an access
    logic                    reg_wr;
    logic                    ctrl_wr;
    logic [`MVU_BADDR-1:0]   off;
    logic [`MVU_WB_DW-1:0]   reg_rd;
    logic [`MVU_WB_DW-1:0]   reg_rd_q;
    logic                    busy;
    logic                    done;

    assign region  = mvu_cfg_pkg::wb_region_e'(adr[`MVU_WB_AW-1 -: 2]);
    assign off     = adr[`MVU_BADDR-1:0];
    assign req     = cyc & stb & ~ack;
    assign reg_wr  = req & we & (region == mvu_cfg_pkg::region_regs);
    assign ctrl_wr = reg_wr & (off == `MVU_REG_CTRL);

    // RAM loads are dropped while a job owns the data
    assign w_we      = req & we & ~busy & (region == mvu_cfg_pkg::region_weights);
    assign d_we      = req & we & ~busy & (region == mvu_cfg_pkg::region_inputs);
    assign bus_waddr = off;
    assign bus_wword = dat_w[$bits(mvu_pipe_pkg::wword_t)-1:0];
    assign bus_dword = dat_w[$bits(mvu_pipe_pkg::dword_t)-1:0];
    assign r_raddr   = off;

    always_comb begin
        reg_rd = '0;
        case (off)
            `MVU_REG_CTRL: begin
                reg_rd[mvu_cfg_pkg::stat_busy_bit] = busy;
                reg_rd[mvu_cfg_pkg::stat_done_bit] = done;
            end
            `MVU_REG_PREC:  reg_rd[13:0] = {cfg.i_signed, cfg.w_signed, 1'b0, cfg.oprec,
                                            1'b0, cfg.iprec, 1'b0, cfg.wprec};
            `MVU_REG_LEN:   reg_rd[3:0]  = cfg.len;
            `MVU_REG_BASE:  reg_rd[21:0] = {cfg.obase, 2'b00, cfg.ibase, 2'b00, cfg.wbase};
            `MVU_REG_SCALE: reg_rd[20:0] = {cfg.quant_msbidx, cfg.scaler_b};
            default:        reg_rd       = '0;
        endcase
    end

    assign dat_r = (region_q == mvu_cfg_pkg::region_results) ? r_rdata : reg_rd_q;

    always_ff @(posedge intf) begin
        region_q <= region;
        reg_rd_q <= reg_rd;
    end

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            irq   <= 1'b0;
            cfg   <= '0;
        end else begin
            ack   <= cyc & stb & ~ack;
            start <= ctrl_wr & dat_w[mvu_cfg_pkg::ctrl_start_bit] & ~busy & ~start;
            if (start) begin                     // New job drops the old status
                busy <= 1'b1;
                done <= 1'b0;
                irq  <= 1'b0;
            end else if (busy_done) begin
                busy <= 1'b0;
                done <= 1'b1;
                irq  <= 1'b1;
            end
            if (ctrl_wr && dat_w[mvu_cfg_pkg::ctrl_clear_bit]) begin
                done <= 1'b0;
                irq  <= 1'b0;
            end
            if (reg_wr && !busy) begin           // Configuration is frozen during a job
                case (off)
                    `MVU_REG_PREC: begin
                        cfg.wprec    <= dat_w[2:0];
                        cfg.iprec    <= dat_w[6:4];
                        cfg.oprec    <= dat_w[10:8];
                        cfg.w_signed <= dat_w[12];
                        cfg.i_signed <= dat_w[13];
                    end
                    `MVU_REG_LEN: cfg.len <= dat_w[3:0];
                    `MVU_REG_BASE: begin
                        cfg.wbase <= dat_w[5:0];
                        cfg.ibase <= dat_w[13:8];
                        cfg.obase <= dat_w[21:16];
                    end
                    `MVU_REG_SCALE: begin
                        cfg.scaler_b     <= dat_w[15:0];
                        cfg.quant_msbidx <= dat_w[20:16];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* mvu_core/mvu_agu.sv */
// Job sequencer walking blocks and bit planes, issuing RAM addresses and plane tags
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_agu (
    input  logic                   intf,
    input  logic                   rst_n,
    input  logic                   start,
    input  mvu_cfg_pkg::job_cfg_t  cfg,
    output logic [`MVU_BADDR-1:0]  waddr,
    output logic [`MVU_BADDR-1:0]  iaddr,
    output mvu_pipe_pkg::plane_t   plane
);

    logic                  run;
    logic [`MVU_BLEN-1:0]  blk;
    logic [`MVU_BPREC-1:0] wbit;
    logic [`MVU_BPREC-1:0] ibit;                 // Innermost
    logic                  ilast;
    logic                  wlast;
    logic                  blast;

    assign ilast = (ibit == cfg.iprec);
    assign wlast = (wbit == cfg.wprec);
    assign blast = (blk == cfg.len);

    // Each block holds all bit planes of one operand back to back
    assign waddr = cfg.wbase + blk * (cfg.wprec + 1'b1) + wbit;
    assign iaddr = cfg.ibase + blk * (cfg.iprec + 1'b1) + ibit;

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            run  <= 1'b0;
            blk  <= '0;
            wbit <= '0;
            ibit <= '0;
        end else if (start) begin
            run <= 1'b1;                         // Counters rest at zero between jobs
        end else if (run) begin
            ibit <= ilast ? '0 : ibit + 1'b1;
            if (ilast) begin
                wbit <= wlast ? '0 : wbit + 1'b1;
                if (wlast) begin
                    blk <= blast ? '0 : blk + 1'b1;
                    run <= ~blast;
                end
            end
        end
    end

    // Tag travels alongside the one-cycle RAM read
    always_ff @(posedge intf) begin
        if (!rst_n) begin
            plane.valid <= 1'b0;
        end else begin
            plane.valid <= run;
        end
        plane.first <= (blk == '0) & (wbit == '0) & (ibit == '0);
        plane.last  <= ilast & wlast & blast;
        plane.shift <= wbit + ibit;
        plane.neg   <= (cfg.w_signed & wlast) ^ (cfg.i_signed & ilast);
    end

endmodule

`default_nettype wire

/* mvu_core/mvu_vvp_acc.sv */
// Bit-plane AND/popcount per row with a sign-aware shifting accumulator
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_vvp_acc (
    input  logic                  intf,
    input  logic                  rst_n,
    input  mvu_pipe_pkg::plane_t  plane,
    input  mvu_pipe_pkg::wword_t  wdata,
    input  mvu_pipe_pkg::dword_t  idata,
    output mvu_pipe_pkg::acc_t    acc
);

    logic [`MVU_BACC-1:0]              mag;      // Shifted popcount of one row
    logic [`MVU_N-1:0][`MVU_BACC-1:0]  term;

    always_comb begin
        mag = '0;
        for (int r = 0; r < `MVU_N; r++) begin
            mag     = `MVU_BACC'($countones(wdata[r*`MVU_N +: `MVU_N] & idata)) << plane.shift;
            term[r] = plane.neg ? -mag : mag;    // MSB plane of a signed operand weighs negative
        end
    end

    // Sums are two's complement, so the add needs no sign handling
    always_ff @(posedge intf) begin
        if (!rst_n) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= plane.valid & plane.last;
        end
        if (plane.valid) begin
            for (int r = 0; r < `MVU_N; r++) begin
                acc.sum[r] <= plane.first ? term[r] : acc.sum[r] + term[r];
            end
        end
    end

endmodule

`default_nettype wire

/* mvu_core/mvu_scale_quant.sv */
// Scaler multiply, quantizer bit select and result-word write
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_scale_quant (
    input  logic                   intf,
    input  logic                   rst_n,
    input  mvu_pipe_pkg::acc_t     acc,
    input  mvu_cfg_pkg::job_cfg_t  cfg,
    output logic                   r_we,
    output logic [`MVU_BADDR-1:0]  r_waddr,
    output mvu_pipe_pkg::rword_t   r_wdata,
    output logic                   done
);

    localparam int pw = `MVU_BACC + `MVU_BSCALER;

    logic                       prod_valid;
    logic [`MVU_N-1:0][pw-1:0]  prod;
    logic [`MVU_BQMSB-1:0]      lsb;             // Product bit that lands in field bit 0
    logic [`MVU_BPREC-1:0]      pad;             // Field bits above the output precision
    logic [pw-1:0]              sh;
    logic [`MVU_OUTW-1:0]       fld;
    mvu_pipe_pkg::rword_t       qword;

    assign lsb = cfg.quant_msbidx - cfg.oprec;
    assign pad = `MVU_BPREC'(`MVU_OUTW - 1) - cfg.oprec;

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= acc.valid;
        end
        if (acc.valid) begin
            for (int r = 0; r < `MVU_N; r++) begin
                prod[r] <= $signed(acc.sum[r]) * $signed({1'b0, cfg.scaler_b});
            end
        end
    end

    always_comb begin
        sh  = '0;
        fld = '0;
        for (int r = 0; r < `MVU_N; r++) begin
            sh  = $signed(prod[r]) >>> lsb;
            fld = sh[`MVU_OUTW-1:0] << pad;      // Field MSB to bit 7
            qword[r*`MVU_OUTW +: `MVU_OUTW] = $signed(fld) >>> pad;
        end
    end

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            r_we <= 1'b0;
        end else begin
            r_we <= prod_valid;
        end
        r_waddr <= cfg.obase;
        r_wdata <= qword;
    end

    assign done = r_we;                          // Result write closes the job

endmodule

`default_nettype wire

/* verilog/mvu_top.sv */
// MVU top level with bus slave, three RAMs and the AGU, accumulator and scaler stages
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_top (
    input  logic                  intf,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [`MVU_WB_AW-1:0] adr,
    input  logic [`MVU_WB_DW-1:0] dat_w,
    output logic [`MVU_WB_DW-1:0] dat_r,
    output logic                  ack,
    output logic                  irq
);

    mvu_cfg_pkg::job_cfg_t  cfg;
    logic                   start;
    logic                   done;
    logic                   w_we;
    logic                   d_we;
    logic [`MVU_BADDR-1:0]  bus_waddr;
    mvu_pipe_pkg::wword_t   bus_wword;
    mvu_pipe_pkg::dword_t   bus_dword;
    logic [`MVU_BADDR-1:0]  r_raddr;
    mvu_pipe_pkg::rword_t   r_rdata;
    logic [`MVU_BADDR-1:0]  waddr;           // Read side of the operand RAMs
    logic [`MVU_BADDR-1:0]  iaddr;
    mvu_pipe_pkg::wword_t   wdata;
    mvu_pipe_pkg::dword_t   idata;
    mvu_pipe_pkg::plane_t   plane;
    mvu_pipe_pkg::acc_t     acc;
    logic                   r_we;
    logic [`MVU_BADDR-1:0]  r_waddr;
    mvu_pipe_pkg::rword_t   r_wdata;

    mvu_wb_regs u_regs (
        .intf      (intf),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .irq       (irq),
        .cfg       (cfg),
        .start     (start),
        .busy_done (done),
        .w_we      (w_we),
        .d_we      (d_we),
        .bus_waddr (bus_waddr),
        .bus_wword (bus_wword),
        .bus_dword (bus_dword),
        .r_raddr   (r_raddr),
        .r_rdata   (r_rdata)
    );

    mvu_ram #(.word_t(mvu_pipe_pkg::wword_t)) u_wram (
        .intf  (intf),
        .we    (w_we),
        .waddr (bus_waddr),
        .wdata (bus_wword),
        .raddr (waddr),
        .rdata (wdata)
    );

    mvu_ram #(.word_t(mvu_pipe_pkg::dword_t)) u_iram (
        .intf  (intf),
        .we    (d_we),
        .waddr (bus_waddr),
        .wdata (bus_dword),
        .raddr (iaddr),
        .rdata (idata)
    );

    mvu_ram #(.word_t(mvu_pipe_pkg::rword_t)) u_rram (
        .intf  (intf),
        .we    (r_we),
        .waddr (r_waddr),
        .wdata (r_wdata),
        .raddr (r_raddr),
        .rdata (r_rdata)
    );

    mvu_agu u_agu (
        .intf  (intf),
        .rst_n (rst_n),
        .start (start),
        .cfg   (cfg),
        .waddr (waddr),
        .iaddr (iaddr),
        .plane (plane)
    );

    mvu_vvp_acc u_vvp (
        .intf  (intf),
        .rst_n (rst_n),
        .plane (plane),
        .wdata (wdata),
        .idata (idata),
        .acc   (acc)
    );

    mvu_scale_quant u_sq (
        .intf    (intf),
        .rst_n   (rst_n),
        .acc     (acc),
        .cfg     (cfg),
        .r_we    (r_we),
        .r_waddr (r_waddr),
        .r_wdata (r_wdata),
        .done    (done)
    );

endmodule

`default_nettype wire

/* tests/mvu_checker.sv */
// Concurrent assertions on the Wishbone handshake, irq and job start, bound into the MVU top
`timescale 1ns/1ps
`default_nettype none

module mvu_checker (
    input  logic intf,
    input  logic rst_n,
    input  logic cyc,
    input  logic stb,
    input  logic ack,
    input  logic irq,
    input  logic start,
    input  logic done
);

    logic job_open;                              // Between start pulse and done pulse

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            job_open <= 1'b0;
        end else if (start) begin
            job_open <= 1'b1;
        end else if (done) begin
            job_open <= 1'b0;
        end
    end

    ack_needs_strobe: assert property (@(posedge intf) disable iff (!rst_n)
        ack |-> (cyc && stb))
        else $error("ack outside of an active bus cycle");

    ack_single_cycle: assert property (@(posedge intf) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack held for two cycles");

    irq_after_job: assert property (@(posedge intf) disable iff (!rst_n)
        $rose(irq) |-> !job_open)
        else $error("irq rose while a job was running");

    start_when_idle: assert property (@(posedge intf) disable iff (!rst_n)
        start |-> !job_open)
        else $error("start pulse while a job was running");

endmodule

bind mvu_top mvu_checker u_checker (
    .intf  (intf),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .irq   (irq),
    .start (start),
    .done  (done)
);

`default_nettype wire

/* tests/mvu_tb.sv */
// MVU testbench with clock, reset, Wishbone tasks, reference model, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "mvu_defines.svh"

module mvu_tb;

    localparam int max_blocks = 16;
    localparam int poll_limit = 200;
    localparam int ack_limit  = 8;
    localparam logic [1:0] rg_regs = 2'd0;      // Bus regions, top two address bits
    localparam logic [1:0] rg_wgt  = 2'd1;
    localparam logic [1:0] rg_inp  = 2'd2;
    localparam logic [1:0] rg_res  = 2'd3;

    logic                  intf;
    logic                  rst_n;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`MVU_WB_AW-1:0] adr;
    logic [`MVU_WB_DW-1:0] dat_w;
    logic [`MVU_WB_DW-1:0] dat_r;
    logic                  ack;
    logic                  irq;

    int unsigned rng;
    int          checks;
    int          errors;

    int wprec;                                   // Current job, precisions stored minus 1
    int iprec;
    int oprec;
    bit w_signed;
    bit i_signed;
    int len;
    int wbase;
    int ibase;
    int obase;
    int scaler;
    int msbidx;

    int wmat [max_blocks][`MVU_N][`MVU_N];       // Raw weight bits by block, row, lane
    int ivec [max_blocks][`MVU_N];

    mvu_top dut (
        .intf  (intf),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .irq   (irq)
    );

    always #5 intf = ~intf;

    function automatic logic [`MVU_WB_AW-1:0] bus_addr(input logic [1:0] rg, input int off);
        return {rg, 8'(off)};
    endfunction

    function automatic int unsigned next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic int operand(input int raw, input int bits_m1, input bit sgn);
        if (sgn && ((raw >> bits_m1) & 1) == 1) begin
            return raw - (1 << (bits_m1 + 1));   // Two's complement value of the field
        end
        return raw;
    endfunction

    function automatic logic [`MVU_N*`MVU_N-1:0] weight_plane(input int b, input int bi);
        logic [`MVU_N*`MVU_N-1:0] w;
        w = '0;
        for (int r = 0; r < `MVU_N; r++) begin
            for (int k = 0; k < `MVU_N; k++) begin
                w[r*`MVU_N + k] = 1'((wmat[b][r][k] >> bi) & 1);
            end
        end
        return w;
    endfunction

    function automatic logic [`MVU_N-1:0] input_plane(input int b, input int bi);
        logic [`MVU_N-1:0] d;
        d = '0;
        for (int k = 0; k < `MVU_N; k++) begin
            d[k] = 1'((ivec[b][k] >> bi) & 1);
        end
        return d;
    endfunction

    // Dot product, scaler, then bits msbidx..msbidx-oprec sign-extended to 8 bits
    function automatic logic [7:0] model_lane(input int r);
        int sum;
        int prod;
        int fld;
        sum = 0;
        for (int b = 0; b <= len; b++) begin
            for (int k = 0; k < `MVU_N; k++) begin
                sum += operand(wmat[b][r][k], wprec, w_signed)
                     * operand(ivec[b][k], iprec, i_signed);
            end
        end
        prod = sum * scaler;
        fld  = (prod >>> (msbidx - oprec)) & ((1 << (oprec + 1)) - 1);
        if (((fld >> oprec) & 1) == 1) begin
            fld = fld - (1 << (oprec + 1));
        end
        return fld[7:0];
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got 0x%0h expected 0x%0h", $time, msg, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic [`MVU_WB_AW-1:0] a, input logic wr,
                             input logic [31:0] wd, output logic [31:0] rd);
        int n;
        @(posedge intf);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wd;
        n     = 0;
        do begin
            @(posedge intf);
            #1;
            n++;
        end while (!ack && n < ack_limit);
        if (!ack) begin
            errors++;
            $display("Bus access to address 0x%0h got no ack at %0t", a, $time);
        end
        rd = dat_r;                              // Valid in the ack cycle
        @(posedge intf);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`MVU_WB_AW-1:0] a, input logic [31:0] d);
        logic [31:0] unused;
        bus_cycle(a, 1'b1, d, unused);
    endtask

    task automatic wb_read(input logic [`MVU_WB_AW-1:0] a, output logic [31:0] d);
        bus_cycle(a, 1'b0, '0, d);
    endtask

    task automatic write_cfg(output logic [31:0] prec_w, output logic [31:0] base_w,
                             output logic [31:0] scale_w);
        prec_w  = 32'(wprec) | (32'(iprec) << 4) | (32'(oprec) << 8)
                | (32'(w_signed) << 12) | (32'(i_signed) << 13);
        base_w  = 32'(wbase) | (32'(ibase) << 8) | (32'(obase) << 16);
        scale_w = 32'(scaler) | (32'(msbidx) << 16);
        wb_write(bus_addr(rg_regs, `MVU_REG_PREC), prec_w);
        wb_write(bus_addr(rg_regs, `MVU_REG_LEN), 32'(len));
        wb_write(bus_addr(rg_regs, `MVU_REG_BASE), base_w);
        wb_write(bus_addr(rg_regs, `MVU_REG_SCALE), scale_w);
    endtask

    // Random operands for every block of the job, then bit planes into the RAMs
    task automatic load_job();
        logic [31:0] p;
        logic [31:0] b;
        logic [31:0] s;
        for (int blk = 0; blk <= len; blk++) begin
            for (int r = 0; r < `MVU_N; r++) begin
                for (int k = 0; k < `MVU_N; k++) begin
                    wmat[blk][r][k] = int'(next_rand() & ((1 << (wprec + 1)) - 1));
                end
                ivec[blk][r] = int'(next_rand() & ((1 << (iprec + 1)) - 1));
            end
            for (int bi = 0; bi <= wprec; bi++) begin
                wb_write(bus_addr(rg_wgt, wbase + blk*(wprec+1) + bi), 32'(weight_plane(blk, bi)));
            end
            for (int bi = 0; bi <= iprec; bi++) begin
                wb_write(bus_addr(rg_inp, ibase + blk*(iprec+1) + bi), 32'(input_plane(blk, bi)));
            end
        end
        write_cfg(p, b, s);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          n;
        st = '0;
        n  = 0;
        while (!st[1] && n < poll_limit) begin
            wb_read(bus_addr(rg_regs, `MVU_REG_CTRL), st);
            n++;
        end
        if (!st[1]) begin
            errors++;
            $display("Job did not finish within %0d status polls at %0t", poll_limit, $time);
        end
    endtask

    task automatic run_job();
        wb_write(bus_addr(rg_regs, `MVU_REG_CTRL), 32'h1);
        wait_done();
    endtask

    task automatic check_result(input string tag);
        logic [31:0] res;
        wb_read(bus_addr(rg_res, obase), res);
        for (int r = 0; r < `MVU_N; r++) begin
            check_eq(32'(res[r*8 +: 8]), 32'(model_lane(r)), $sformatf("%s lane %0d", tag, r));
        end
    endtask

    task automatic end_test(input string name, input int e0);
        $display("test %-16s %s", name, (errors == e0) ? "ok" : "had errors");
    endtask

    task automatic set_job(input int wp, input int ip, input int op, input bit ws, input bit is,
                           input int ln, input int ob, input int sc, input int msb);
        wprec    = wp;
        iprec    = ip;
        oprec    = op;
        w_signed = ws;
        i_signed = is;
        len      = ln;
        wbase    = 0;
        ibase    = 0;
        obase    = ob;
        scaler   = sc;
        msbidx   = msb;
    endtask

    task automatic test_reset_regs();
        int          e0;
        logic [31:0] d;
        logic [31:0] p;
        logic [31:0] b;
        logic [31:0] s;
        e0 = errors;
        wb_read(bus_addr(rg_regs, `MVU_REG_CTRL), d);
        check_eq(d, 32'h0, "CTRL after reset");
        check_eq(32'(irq), 32'h0, "irq after reset");
        set_job(3, 7, 2, 1'b1, 1'b1, 5, 21, 16'h1234, 27);
        wbase = 7;
        ibase = 42;
        write_cfg(p, b, s);
        wb_read(bus_addr(rg_regs, `MVU_REG_PREC), d);
        check_eq(d, p, "PREC readback");
        wb_read(bus_addr(rg_regs, `MVU_REG_LEN), d);
        check_eq(d, 32'(len), "LEN readback");
        wb_read(bus_addr(rg_regs, `MVU_REG_BASE), d);
        check_eq(d, b, "BASE readback");
        wb_read(bus_addr(rg_regs, `MVU_REG_SCALE), d);
        check_eq(d, s, "SCALE readback");
        end_test("reset_regs", e0);
    endtask

    task automatic test_popcount();
        int                       e0;
        logic [31:0]              res;
        logic [`MVU_N*`MVU_N-1:0] wp;
        logic [`MVU_N-1:0]        ip;
        e0 = errors;
        set_job(0, 0, 7, 1'b0, 1'b0, 0, 0, 1, 7);
        load_job();
        run_job();
        wb_read(bus_addr(rg_res, obase), res);
        wp = weight_plane(0, 0);
        ip = input_plane(0, 0);
        for (int r = 0; r < `MVU_N; r++) begin
            check_eq(32'(res[r*8 +: 8]), 32'($countones(wp[r*`MVU_N +: `MVU_N] & ip)),
                     $sformatf("popcount lane %0d", r));
        end
        end_test("popcount", e0);
    endtask

    task automatic test_unsigned_multi();
        int e0;
        e0 = errors;
        set_job(2, 3, 7, 1'b0, 1'b0, 2, 1, 1, 7);
        wbase = 20;                              // Operands away from address 0
        ibase = 33;
        load_job();
        run_job();
        check_result("unsigned");
        check_eq(32'(irq), 32'h1, "irq after unsigned job");
        end_test("unsigned_multi", e0);
    endtask

    task automatic test_signed();
        int e0;
        e0 = errors;
        for (int m = 1; m <= 3; m++) begin       // Weights, inputs, then both signed
            set_job(3, 2, 7, m[0], m[1], 1, 2 + m, 1, 7);
            load_job();
            run_job();
            check_result($sformatf("signed mode %0d", m));
        end
        end_test("signed", e0);
    endtask

    task automatic test_scale_quant();
        int          e0;
        logic [31:0] d;
        e0 = errors;
        set_job(2, 2, 3, 1'b1, 1'b1, 1, 8, 5, 6);
        load_job();
        run_job();
        check_result("scaled");
        check_eq(32'(irq), 32'h1, "irq before clear");
        wb_write(bus_addr(rg_regs, `MVU_REG_CTRL), 32'h2);
        wb_read(bus_addr(rg_regs, `MVU_REG_CTRL), d);
        check_eq(d, 32'h0, "CTRL after clear");
        check_eq(32'(irq), 32'h0, "irq after clear");
        end_test("scale_quant", e0);
    endtask

    task automatic test_busy_writes();
        int          e0;
        logic [31:0] d;
        e0 = errors;
        set_job(3, 3, 7, 1'b0, 1'b0, 3, 9, 3, 9);    // 64 planes, long enough to overlap
        load_job();
        wb_write(bus_addr(rg_regs, `MVU_REG_CTRL), 32'h1);
        for (int bi = 0; bi <= wprec; bi++) begin
            wb_write(bus_addr(rg_wgt, wbase + bi), 32'(~weight_plane(0, bi)));
        end
        wb_read(bus_addr(rg_regs, `MVU_REG_CTRL), d);
        check_eq(32'(d[0]), 32'h1, "busy during weight writes");
        wait_done();
        check_result("first job");
        run_job();
        check_result("second job");
        end_test("busy_writes", e0);
    endtask

    initial begin
        intf   = 1'b0;
        rst_n  = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        rng    = 2311;
        checks = 0;
        errors = 0;
        repeat (3) @(posedge intf);
        #1;
        rst_n = 1'b1;
        test_reset_regs();
        test_popcount();
        test_unsigned_multi();
        test_signed();
        test_scale_quant();
        test_busy_writes();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // All jobs here are under a few hundred planes, so 200 us leaves ample margin
    initial begin
        #200_000;
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mvu_top.f */
+incdir+common
common/mvu_cfg_pkg.sv
common/mvu_pipe_pkg.sv
verilog/mvu_ram.sv
verilog/mvu_wb_regs.sv
mvu_core/mvu_agu.sv
mvu_core/mvu_vvp_acc.sv
mvu_core/mvu_scale_quant.sv
verilog/mvu_top.sv
tests/mvu_checker.sv
tests/mvu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mvu_tb -f mvu_top.f -o mvu_sim
./obj_dir/mvu_sim | tee sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi
